// ==== ooo_pkg.sv ====
// ooo_pkg: data widths, register index width, zero register and the opcode enum
`default_nettype none

package ooo_pkg;

    localparam int data_width    = 32; // register value and pc
    localparam int reg_idx_width = 5;  // 32 architectural registers

    // never written, never renamed, always reads zero
    localparam logic [reg_idx_width-1:0] zero_reg = '0;

    // op_beq result is the target pc + imm, taken when src1 == src2
    typedef enum logic [2:0] {
        op_add,
        op_sub,
        op_and,
        op_or,
        op_xor,
        op_beq,
        op_halt  // stops retirement at the ROB head
    } alu_op_t;

endpackage

`default_nettype wire

// ==== arch_regfile.sv ====
// arch_regfile: architectural registers, two rename reads, retire write, debug read
`timescale 1ns/1ps
`default_nettype none

module arch_regfile import ooo_pkg::*; (
    input  wire logic                     clock,
    input  wire logic                     reset,
    input  wire logic [reg_idx_width-1:0] read_idx1,
    input  wire logic [reg_idx_width-1:0] read_idx2,
    input  wire logic [reg_idx_width-1:0] debug_idx,
    output logic      [data_width-1:0]    read_data1,
    output logic      [data_width-1:0]    read_data2,
    output logic      [data_width-1:0]    debug_data,
    input  wire logic                     write_en,
    input  wire logic [reg_idx_width-1:0] write_idx,
    input  wire logic [data_width-1:0]    write_data
);

    logic [data_width-1:0] regs [2**reg_idx_width];

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < 2**reg_idx_width; i++) regs[i] <= '0;
        end else if (write_en && write_idx != zero_reg) begin
            regs[write_idx] <= write_data; // r0 stays zero
        end
    end

    assign read_data1 = (read_idx1 == zero_reg) ? '0 : regs[read_idx1];
    assign read_data2 = (read_idx2 == zero_reg) ? '0 : regs[read_idx2];
    assign debug_data = (debug_idx == zero_reg) ? '0 : regs[debug_idx];

endmodule

`default_nettype wire

// ==== alu_unit.sv ====
// alu_unit: single-cycle ALU and branch compare with a registered CDB output
`timescale 1ns/1ps
`default_nettype none

module alu_unit import ooo_pkg::*; #(
    parameter int rob_depth = 8
) (
    input  wire logic                         clock,
    input  wire logic                         reset,
    input  wire logic                         squash,
    input  wire logic                         issue_valid,
    input  wire alu_op_t                      issue_op,
    input  wire logic [data_width-1:0]        issue_value1,
    input  wire logic [data_width-1:0]        issue_value2,
    input  wire logic [data_width-1:0]        issue_imm,
    input  wire logic [data_width-1:0]        issue_pc,
    input  wire logic [$clog2(rob_depth)-1:0] issue_tag,
    output logic                              cdb_valid,
    output logic      [$clog2(rob_depth)-1:0] cdb_tag,
    output logic      [data_width-1:0]        cdb_value,
    output logic                              cdb_taken
);

    logic [data_width-1:0] result;
    logic                  taken;

    always_comb begin
        taken = 1'b0;
        case (issue_op)
            op_add:  result = issue_value1 + issue_value2;
            op_sub:  result = issue_value1 - issue_value2;
            op_and:  result = issue_value1 & issue_value2;
            op_or:   result = issue_value1 | issue_value2;
            op_xor:  result = issue_value1 ^ issue_value2;
            op_beq: begin
                result = issue_pc + issue_imm;             // branch target
                taken  = (issue_value1 == issue_value2);
            end
            default: result = '0; // halt never issues
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset || squash) cdb_valid <= 1'b0;  // drop in-flight younger result
        else                 cdb_valid <= issue_valid;
    end

    always_ff @(posedge clock) begin
        cdb_tag   <= issue_tag;
        cdb_value <= result;
        cdb_taken <= taken;
    end

endmodule

`default_nettype wire

// ==== rename_stage.sv ====
// rename_stage: map table, source operand resolution and reservation station write
`timescale 1ns/1ps
`default_nettype none

module rename_stage import ooo_pkg::*; #(
    parameter int rob_depth = 8
) (
    input  wire logic                         clock,
    input  wire logic                         reset,
    input  wire logic                         dispatch_valid,
    input  wire alu_op_t                      dispatch_op,
    input  wire logic [reg_idx_width-1:0]     dispatch_dest,
    input  wire logic [reg_idx_width-1:0]     dispatch_src1,
    input  wire logic [reg_idx_width-1:0]     dispatch_src2,
    input  wire logic [data_width-1:0]        dispatch_imm,
    input  wire logic [data_width-1:0]        dispatch_pc,
    input  wire logic                         dispatch_stall,
    input  wire logic [$clog2(rob_depth)-1:0] alloc_tag,
    input  wire logic                         retire_valid,
    input  wire logic [$clog2(rob_depth)-1:0] retire_tag,
    input  wire logic                         squash,
    output logic      [reg_idx_width-1:0]     rf_read_idx1,
    output logic      [reg_idx_width-1:0]     rf_read_idx2,
    input  wire logic [data_width-1:0]        rf_read_data1,
    input  wire logic [data_width-1:0]        rf_read_data2,
    output logic      [$clog2(rob_depth)-1:0] rob_read_tag1,
    output logic      [$clog2(rob_depth)-1:0] rob_read_tag2,
    input  wire logic                         rob_read_done1,
    input  wire logic                         rob_read_done2,
    input  wire logic [data_width-1:0]        rob_read_value1,
    input  wire logic [data_width-1:0]        rob_read_value2,
    output logic                              rs_write,
    output alu_op_t                           rs_op,
    output logic                              rs_ready1,
    output logic                              rs_ready2,
    output logic      [data_width-1:0]        rs_value1,
    output logic      [data_width-1:0]        rs_value2,
    output logic      [$clog2(rob_depth)-1:0] rs_tag1,
    output logic      [$clog2(rob_depth)-1:0] rs_tag2,
    output logic      [data_width-1:0]        rs_imm,
    output logic      [data_width-1:0]        rs_pc,
    output logic      [$clog2(rob_depth)-1:0] rs_tag,
    output logic                              alloc_writes
);

    localparam int tag_width = $clog2(rob_depth);

    logic [2**reg_idx_width-1:0] busy;              // value still in flight
    logic [tag_width-1:0]        tag_map [2**reg_idx_width];
    logic                        accept;

    assign accept       = dispatch_valid && !dispatch_stall;
    assign alloc_writes = (dispatch_dest != zero_reg) && dispatch_op != op_beq
                          && dispatch_op != op_halt;

    // sources see the map before this instruction renames its dest
    assign rf_read_idx1  = dispatch_src1;
    assign rf_read_idx2  = dispatch_src2;
    assign rob_read_tag1 = tag_map[dispatch_src1];
    assign rob_read_tag2 = tag_map[dispatch_src2];

    assign rs_write  = accept && dispatch_op != op_halt; // halt lives in the ROB only
    assign rs_op     = dispatch_op;
    assign rs_ready1 = !busy[dispatch_src1] || rob_read_done1;
    assign rs_ready2 = !busy[dispatch_src2] || rob_read_done2;
    assign rs_value1 = busy[dispatch_src1] ? rob_read_value1 : rf_read_data1;
    assign rs_value2 = busy[dispatch_src2] ? rob_read_value2 : rf_read_data2;
    assign rs_tag1   = tag_map[dispatch_src1];
    assign rs_tag2   = tag_map[dispatch_src2];
    assign rs_imm    = dispatch_imm;
    assign rs_pc     = dispatch_pc;
    assign rs_tag    = alloc_tag;

    always_ff @(posedge clock) begin
        if (reset || squash) begin
            busy <= '0;
        end else begin
            if (retire_valid) begin
                for (int r = 0; r < 2**reg_idx_width; r++)
                    if (tag_map[r] == retire_tag) busy[r] <= 1'b0; // only if not renamed since
            end
            if (accept && alloc_writes) begin // newer rename wins over retire clear
                busy[dispatch_dest]    <= 1'b1;
                tag_map[dispatch_dest] <= alloc_tag;
            end
        end
    end

endmodule

`default_nettype wire

// ==== res_station.sv ====
// res_station: operand wait, CDB snoop and oldest-ready issue
`timescale 1ns/1ps
`default_nettype none

module res_station import ooo_pkg::*; #(
    parameter int rs_depth  = 4,
    parameter int rob_depth = 8
) (
    input  wire logic                         clock,
    input  wire logic                         reset,
    input  wire logic                         squash,
    input  wire logic                         rs_write,
    input  wire alu_op_t                      rs_op,
    input  wire logic                         rs_ready1,
    input  wire logic                         rs_ready2,
    input  wire logic [data_width-1:0]        rs_value1,
    input  wire logic [data_width-1:0]        rs_value2,
    input  wire logic [$clog2(rob_depth)-1:0] rs_tag1,
    input  wire logic [$clog2(rob_depth)-1:0] rs_tag2,
    input  wire logic [data_width-1:0]        rs_imm,
    input  wire logic [data_width-1:0]        rs_pc,
    input  wire logic [$clog2(rob_depth)-1:0] rs_tag,
    input  wire logic                         cdb_valid,
    input  wire logic [$clog2(rob_depth)-1:0] cdb_tag,
    input  wire logic [data_width-1:0]        cdb_value,
    output logic                              rs_full,
    output logic                              issue_valid,
    output alu_op_t                           issue_op,
    output logic      [data_width-1:0]        issue_value1,
    output logic      [data_width-1:0]        issue_value2,
    output logic      [data_width-1:0]        issue_imm,
    output logic      [data_width-1:0]        issue_pc,
    output logic      [$clog2(rob_depth)-1:0] issue_tag
);

    localparam int tag_width = $clog2(rob_depth);
    localparam int idx_width = $clog2(rs_depth);
    localparam int age_width = $clog2(rs_depth) + 1;

    logic [rs_depth-1:0]   valid, ready1, ready2, hit1, hit2;
    alu_op_t               op     [rs_depth];
    logic [data_width-1:0] value1 [rs_depth];
    logic [data_width-1:0] value2 [rs_depth];
    logic [data_width-1:0] imm    [rs_depth];
    logic [data_width-1:0] pc     [rs_depth];
    logic [tag_width-1:0]  tag1   [rs_depth];
    logic [tag_width-1:0]  tag2   [rs_depth];
    logic [tag_width-1:0]  tag    [rs_depth];
    logic [age_width-1:0]  age    [rs_depth]; // 0 is oldest
    logic [idx_width-1:0]  issue_idx, free_idx;
    logic [age_width-1:0]  occupancy, best_age;

    assign rs_full = &valid;

    always_comb begin
        occupancy   = '0;
        free_idx    = '0;
        issue_valid = 1'b0;
        issue_idx   = '0;
        best_age    = '0;
        for (int i = 0; i < rs_depth; i++) begin
            hit1[i] = cdb_valid && cdb_tag == tag1[i];
            hit2[i] = cdb_valid && cdb_tag == tag2[i];
            if (valid[i]) occupancy = occupancy + 1'b1;
            else          free_idx  = idx_width'(i);
            if (valid[i] && (ready1[i] || hit1[i]) && (ready2[i] || hit2[i])
                && (!issue_valid || age[i] < best_age)) begin
                issue_valid = 1'b1;
                issue_idx   = idx_width'(i);
                best_age    = age[i];
            end
        end
    end

    // operands caught on the CDB this cycle bypass straight to the ALU
    assign issue_op     = op[issue_idx];
    assign issue_value1 = ready1[issue_idx] ? value1[issue_idx] : cdb_value;
    assign issue_value2 = ready2[issue_idx] ? value2[issue_idx] : cdb_value;
    assign issue_imm    = imm[issue_idx];
    assign issue_pc     = pc[issue_idx];
    assign issue_tag    = tag[issue_idx];

    always_ff @(posedge clock) begin
        if (reset || squash) begin
            valid <= '0;
        end else begin
            for (int i = 0; i < rs_depth; i++) begin
                if (valid[i]) begin
                    if (hit1[i] && !ready1[i]) begin
                        ready1[i] <= 1'b1;
                        value1[i] <= cdb_value;
                    end
                    if (hit2[i] && !ready2[i]) begin
                        ready2[i] <= 1'b1;
                        value2[i] <= cdb_value;
                    end
                    if (issue_valid && age[i] > best_age) age[i] <= age[i] - 1'b1;
                end
            end
            if (issue_valid) valid[issue_idx] <= 1'b0;
            if (rs_write) begin
                valid[free_idx]  <= 1'b1;
                op[free_idx]     <= rs_op;
                // producer may be on the CDB while we are written
                ready1[free_idx] <= rs_ready1 || (cdb_valid && cdb_tag == rs_tag1);
                ready2[free_idx] <= rs_ready2 || (cdb_valid && cdb_tag == rs_tag2);
                value1[free_idx] <= rs_ready1 ? rs_value1 : cdb_value;
                value2[free_idx] <= rs_ready2 ? rs_value2 : cdb_value;
                tag1[free_idx]   <= rs_tag1;
                tag2[free_idx]   <= rs_tag2;
                imm[free_idx]    <= rs_imm;
                pc[free_idx]     <= rs_pc;
                tag[free_idx]    <= rs_tag;
                age[free_idx]    <= issue_valid ? occupancy - 1'b1 : occupancy; // youngest
            end
        end
    end

endmodule

`default_nettype wire

// ==== rob.sv ====
// rob: reorder buffer with allocation, completion, in-order retire, squash and halt
`timescale 1ns/1ps
`default_nettype none

module rob import ooo_pkg::*; #(
    parameter int rob_depth = 8
) (
    input  wire logic                         clock,
    input  wire logic                         reset,
    input  wire logic                         dispatch_valid,
    input  wire alu_op_t                      dispatch_op,
    input  wire logic [reg_idx_width-1:0]     dispatch_dest,
    input  wire logic [data_width-1:0]        dispatch_pc,
    input  wire logic                         alloc_writes,
    input  wire logic                         rs_full,
    output logic                              dispatch_stall,
    output logic      [$clog2(rob_depth)-1:0] alloc_tag,
    input  wire logic                         cdb_valid,
    input  wire logic [$clog2(rob_depth)-1:0] cdb_tag,
    input  wire logic [data_width-1:0]        cdb_value,
    input  wire logic                         cdb_taken,
    input  wire logic [$clog2(rob_depth)-1:0] rob_read_tag1,
    input  wire logic [$clog2(rob_depth)-1:0] rob_read_tag2,
    output logic                              rob_read_done1,
    output logic                              rob_read_done2,
    output logic      [data_width-1:0]        rob_read_value1,
    output logic      [data_width-1:0]        rob_read_value2,
    output logic                              retire_valid,
    output logic      [$clog2(rob_depth)-1:0] retire_tag,
    output logic      [reg_idx_width-1:0]     retire_dest,
    output logic      [data_width-1:0]        retire_value,
    output logic      [data_width-1:0]        retire_pc,
    output logic                              retire_writes,
    output logic                              squash,
    output logic      [data_width-1:0]        redirect_pc,
    output logic                              halted
);

    localparam int tag_width = $clog2(rob_depth);

    logic [tag_width-1:0]     head, tail, head_next, tail_next;
    logic [tag_width:0]       count;
    logic                     alloc;
    logic [rob_depth-1:0]     done, writes, taken, halt;
    logic [reg_idx_width-1:0] dest  [rob_depth];
    logic [data_width-1:0]    value [rob_depth]; // branch target for op_beq
    logic [data_width-1:0]    pc    [rob_depth];

    assign head_next = (head == tag_width'(rob_depth - 1)) ? '0 : head + 1'b1;
    assign tail_next = (tail == tag_width'(rob_depth - 1)) ? '0 : tail + 1'b1;

    assign dispatch_stall = (count == (tag_width + 1)'(rob_depth)) || rs_full || squash || halted;
    assign alloc          = dispatch_valid && !dispatch_stall;
    assign alloc_tag      = tail;

    assign rob_read_done1  = done[rob_read_tag1];
    assign rob_read_done2  = done[rob_read_tag2];
    assign rob_read_value1 = value[rob_read_tag1];
    assign rob_read_value2 = value[rob_read_tag2];

    // head retires once done, unless a halt already retired
    assign retire_valid  = (count != '0) && done[head] && !halted;
    assign retire_tag    = head;
    assign retire_dest   = dest[head];
    assign retire_value  = value[head];
    assign retire_pc     = pc[head];
    assign retire_writes = retire_valid && writes[head];
    assign squash        = retire_valid && taken[head]; // predicted not taken
    assign redirect_pc   = value[head];

    always_ff @(posedge clock) begin
        if (reset) begin
            head   <= '0;
            tail   <= '0;
            count  <= '0;
            halted <= 1'b0;
        end else begin
            if (retire_valid && halt[head]) halted <= 1'b1; // sticky till reset
            if (squash) begin  // empty the buffer
                head  <= '0;
                tail  <= '0;
                count <= '0;
            end else begin
                if (alloc)        tail <= tail_next;
                if (retire_valid) head <= head_next;
                count <= count + (tag_width + 1)'(alloc) - (tag_width + 1)'(retire_valid);
            end
        end
    end

    // entry payload
    always_ff @(posedge clock) begin
        if (cdb_valid) begin
            done[cdb_tag]  <= 1'b1;
            value[cdb_tag] <= cdb_value;
            taken[cdb_tag] <= cdb_taken;
        end
        if (alloc) begin
            done[tail]   <= (dispatch_op == op_halt); // halt needs no execution
            writes[tail] <= alloc_writes;
            taken[tail]  <= 1'b0;
            halt[tail]   <= (dispatch_op == op_halt);
            dest[tail]   <= dispatch_dest;
            pc[tail]     <= dispatch_pc;
        end
    end

endmodule

`default_nettype wire

// ==== ooo_core.sv ====
// ooo_core: top level joining rename, reservation station, ALU, ROB and register file
`timescale 1ns/1ps
`default_nettype none

module ooo_core import ooo_pkg::*; #(
    parameter int rob_depth = 8,
    parameter int rs_depth  = 4
) (
    input  wire logic                     clock,
    input  wire logic                     reset,
    input  wire logic                     dispatch_valid,
    input  wire alu_op_t                  dispatch_op,
    input  wire logic [reg_idx_width-1:0] dispatch_dest,
    input  wire logic [reg_idx_width-1:0] dispatch_src1,
    input  wire logic [reg_idx_width-1:0] dispatch_src2,
    input  wire logic [data_width-1:0]    dispatch_imm,
    input  wire logic [data_width-1:0]    dispatch_pc,
    output logic                          dispatch_stall,
    output logic                          retire_valid,
    output logic      [reg_idx_width-1:0] retire_dest,
    output logic      [data_width-1:0]    retire_value,
    output logic      [data_width-1:0]    retire_pc,
    output logic                          retire_writes,
    output logic                          squash,
    output logic      [data_width-1:0]    redirect_pc,
    output logic                          halted,
    input  wire logic [reg_idx_width-1:0] arch_read_idx,
    output logic      [data_width-1:0]    arch_read_data
);

    localparam int tag_width = $clog2(rob_depth);

    logic [tag_width-1:0]     alloc_tag, retire_tag, rob_read_tag1, rob_read_tag2;
    logic                     alloc_writes, rob_read_done1, rob_read_done2;
    logic [data_width-1:0]    rob_read_value1, rob_read_value2, rf_read_data1, rf_read_data2;
    logic [reg_idx_width-1:0] rf_read_idx1, rf_read_idx2;
    logic                     rs_write, rs_ready1, rs_ready2, rs_full;
    alu_op_t                  rs_op, issue_op;
    logic [data_width-1:0]    rs_value1, rs_value2, rs_imm, rs_pc;
    logic [tag_width-1:0]     rs_tag1, rs_tag2, rs_tag, issue_tag, cdb_tag;
    logic                     issue_valid, cdb_valid, cdb_taken;
    logic [data_width-1:0]    issue_value1, issue_value2, issue_imm, issue_pc, cdb_value;

    rename_stage #(.rob_depth(rob_depth)) rename_inst (.*);

    res_station #(.rs_depth(rs_depth), .rob_depth(rob_depth)) rs_inst (.*);

    alu_unit #(.rob_depth(rob_depth)) alu_inst (.*);

    rob #(.rob_depth(rob_depth)) rob_inst (.*);

    arch_regfile regfile_inst (
        .clock      (clock),
        .reset      (reset),
        .read_idx1  (rf_read_idx1),
        .read_idx2  (rf_read_idx2),
        .debug_idx  (arch_read_idx),
        .read_data1 (rf_read_data1),
        .read_data2 (rf_read_data2),
        .debug_data (arch_read_data),
        .write_en   (retire_writes), // already gated by retire_valid
        .write_idx  (retire_dest),
        .write_data (retire_value)
    );

endmodule

`default_nettype wire

// ==== ooo_core_tb.sv ====
// ooo_core_tb: clock, reset, program stimulus, sequential reference model and checks
`timescale 1ns/1ps
`default_nettype none

module ooo_core_tb import ooo_pkg::*; ;

    localparam int rob_depth     = 8;
    localparam int random_len    = 40;
    localparam int chain_len     = 16;
    localparam int branch_rounds = 3;
    localparam int after_branch  = 4;
    localparam int halt_len      = 6;
    localparam int num_instrs    = random_len + chain_len
                                   + branch_rounds * (1 + after_branch) + halt_len;
    localparam int cycle_limit   = 40 * num_instrs + 200;

    localparam logic [1:0] kind_normal = 2'd0;
    localparam logic [1:0] kind_fall   = 2'd1; // beq not taken
    localparam logic [1:0] kind_taken  = 2'd2;
    localparam logic [1:0] kind_halt   = 2'd3;

    logic clock, reset, dispatch_valid, dispatch_stall, retire_valid, retire_writes;
    logic squash, halted;
    alu_op_t dispatch_op;
    logic [reg_idx_width-1:0] dispatch_dest, dispatch_src1, dispatch_src2, retire_dest;
    logic [reg_idx_width-1:0] arch_read_idx;
    logic [data_width-1:0] dispatch_imm, dispatch_pc, retire_value, retire_pc;
    logic [data_width-1:0] redirect_pc, arch_read_data;

    integer seed, errors, retired, cycles, inflight;
    logic [data_width-1:0]    next_pc;
    logic [data_width-1:0]    model_regs [2**reg_idx_width];
    logic                     squash_pending, model_stopped, halt_retired, accepted;
    logic [reg_idx_width-1:0] branch_src;
    logic [1:0]               exp_kind   [$];
    logic [reg_idx_width-1:0] exp_dest   [$];
    logic [data_width-1:0]    exp_value  [$];
    logic [data_width-1:0]    exp_pc     [$];
    logic                     exp_writes [$];

    ooo_core ooo_core_inst (.*);

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    always @(posedge clock) begin
        cycles = cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("timeout: run stopped after %0d cycles without finishing", cycles);
            $display("Test failed");
            $finish;
        end
    end

    task automatic log_mismatch(input string msg);
        $display("error at %0t ns: %s", $time, msg);
        errors = errors + 1;
    endtask

    function automatic logic [reg_idx_width-1:0] random_reg();
        random_reg = reg_idx_width'($unsigned($random(seed)) % 8); // small set, many deps
    endfunction

    // a register whose model value differs from r, so a beq falls through
    function automatic logic [reg_idx_width-1:0] differing_reg(
        input logic [reg_idx_width-1:0] r
    );
        differing_reg = r + 1'b1;
        for (int i = 0; i < 2**reg_idx_width; i++)
            if (model_regs[i] != model_regs[r]) differing_reg = reg_idx_width'(i);
    endfunction

    // sequential execution of one accepted instruction
    task automatic model_dispatch();
        logic [data_width-1:0] a, b, r;
        logic [1:0]            kind;
        logic                  w;
        if (squash_pending || model_stopped) return; // wrong path or past halt
        a    = model_regs[dispatch_src1];
        b    = model_regs[dispatch_src2];
        r    = '0;
        kind = kind_normal;
        w    = 1'b0;
        case (dispatch_op)
            op_add: r = a + b;
            op_sub: r = a - b;
            op_and: r = a & b;
            op_or:  r = a | b;
            op_xor: r = a ^ b;
            op_beq: begin
                r    = dispatch_pc + dispatch_imm;
                kind = (a == b) ? kind_taken : kind_fall;
            end
            default: kind = kind_halt;
        endcase
        if (kind == kind_taken) squash_pending = 1'b1;
        if (kind == kind_halt)  model_stopped  = 1'b1;
        if (kind == kind_normal && dispatch_dest != zero_reg) begin
            w = 1'b1;
            model_regs[dispatch_dest] = r;
        end
        exp_kind.push_back(kind);
        exp_dest.push_back(dispatch_dest);
        exp_value.push_back(r);
        exp_pc.push_back(dispatch_pc);
        exp_writes.push_back(w);
    endtask

    task automatic check_retirement();
        logic [1:0]            kind;
        logic [data_width-1:0] v;
        if (exp_pc.size() == 0) begin
            log_mismatch($sformatf("unexpected retirement of pc %h", retire_pc));
            return;
        end
        kind = exp_kind.pop_front();
        v    = exp_value.pop_front();
        assert (retire_pc == exp_pc.pop_front())
            else log_mismatch($sformatf("retire_pc %h out of order", retire_pc));
        assert (retire_dest == exp_dest.pop_front())
            else log_mismatch($sformatf("retire_dest %0d wrong", retire_dest));
        assert (retire_writes == exp_writes.pop_front())
            else log_mismatch($sformatf("retire_writes %b wrong", retire_writes));
        if (kind != kind_halt)
            assert (retire_value == v)
                else log_mismatch($sformatf("retire_value %h, expected %h", retire_value, v));
        if (retire_dest == zero_reg)
            assert (!retire_writes) else log_mismatch("zero_reg retired with retire_writes");
        assert (squash == (kind == kind_taken))
            else log_mismatch($sformatf("squash %b at retire of kind %0d", squash, kind));
        if (kind == kind_taken)
            assert (redirect_pc == v)
                else log_mismatch($sformatf("redirect_pc %h, expected %h", redirect_pc, v));
        if (kind == kind_halt) halt_retired = 1'b1;
        retired = retired + 1;
    endtask

    // everything sampled mid-cycle, inputs already settled
    always @(negedge clock) begin
        if (!reset) begin
            accepted = dispatch_valid && !dispatch_stall;
            assert (inflight <= rob_depth)
                else log_mismatch($sformatf("%0d instructions in flight", inflight));
            if (inflight == rob_depth)
                assert (dispatch_stall) else log_mismatch("no stall with the ROB full");
            if (halt_retired) begin
                assert (halted) else log_mismatch("halted low after halt retired");
                assert (dispatch_stall) else log_mismatch("dispatch_stall low after halt");
                assert (!retire_valid) else log_mismatch("retirement after halt");
            end else begin
                assert (!halted) else log_mismatch("halted before halt retired");
            end
            if (retire_valid) check_retirement();
            if (squash) squash_pending = 1'b0;
            if (accepted) model_dispatch();
            if (retire_valid && squash) inflight = 0;
            else inflight = inflight + (accepted ? 1 : 0) - (retire_valid ? 1 : 0);
        end
    end

    task automatic dispatch_instr(input alu_op_t op, input logic [reg_idx_width-1:0] dest,
                                  input logic [reg_idx_width-1:0] src1,
                                  input logic [reg_idx_width-1:0] src2,
                                  input logic [data_width-1:0] imm);
        dispatch_valid = 1'b1;
        dispatch_op    = op;
        dispatch_dest  = dest;
        dispatch_src1  = src1;
        dispatch_src2  = src2;
        dispatch_imm   = imm;
        dispatch_pc    = next_pc;
        @(negedge clock);
        while (dispatch_stall) @(negedge clock); // hold until accepted
        @(posedge clock);
        #1;
        dispatch_valid = 1'b0;
        next_pc        = next_pc + 4;
    endtask

    // one cycle only, accepted or not
    task automatic offer_instr(input alu_op_t op, input logic [reg_idx_width-1:0] dest);
        dispatch_valid = 1'b1;
        dispatch_op    = op;
        dispatch_dest  = dest;
        dispatch_src1  = random_reg();
        dispatch_src2  = random_reg();
        dispatch_pc    = next_pc;
        @(posedge clock);
        #1;
        dispatch_valid = 1'b0;
        next_pc        = next_pc + 4;
    endtask

    task automatic dispatch_random();
        dispatch_instr(alu_op_t'($unsigned($random(seed)) % 5), random_reg(), random_reg(),
                       random_reg(), $random(seed));
    endtask

    task automatic wait_for_drain();
        while (exp_pc.size() != 0) @(negedge clock);
        @(posedge clock); // last retire writes the register file here
        #1;
    endtask

    task automatic compare_arch_state(input logic use_model);
        for (int i = 0; i < 2**reg_idx_width; i++) begin
            arch_read_idx = reg_idx_width'(i);
            @(negedge clock);
            assert (arch_read_data == (use_model ? model_regs[i] : '0))
                else log_mismatch($sformatf("r%0d reads %h", i, arch_read_data));
            @(posedge clock);
            #1;
        end
    endtask

    initial begin
        seed = 32'h5bcf8e94;
        errors = 0;
        retired = 0;
        cycles = 0;
        inflight = 0;
        next_pc = 32'h1000;
        squash_pending = 1'b0;
        model_stopped = 1'b0;
        halt_retired = 1'b0;
        branch_src = '0;
        for (int i = 0; i < 2**reg_idx_width; i++) model_regs[i] = '0;
        reset = 1'b1;
        dispatch_valid = 1'b0;
        dispatch_op = op_add;
        dispatch_dest = '0;
        dispatch_src1 = '0;
        dispatch_src2 = '0;
        dispatch_imm = '0;
        dispatch_pc = '0;
        arch_read_idx = '0;
        repeat (10) @(posedge clock);
        #1;
        reset = 1'b0;
        @(negedge clock);
        assert (!retire_valid && !squash && !halted && !dispatch_stall)
            else log_mismatch("status outputs high after reset");
        @(posedge clock);
        #1;
        compare_arch_state(1'b0);
        repeat (random_len) dispatch_random();
        for (int i = 0; i < chain_len; i++)
            dispatch_instr((i % 2) ? op_sub : op_add, 5'd3, 5'd3, 5'd3, '0); // serial chain
        for (int k = 0; k < branch_rounds; k++) begin
            branch_src = random_reg();
            // even rounds taken, odd rounds fall through
            dispatch_instr(op_beq, zero_reg, branch_src,
                           (k % 2) ? differing_reg(branch_src) : branch_src,
                           32'h40 * (k + 1));
            repeat (after_branch) dispatch_random();
        end
        wait_for_drain();
        compare_arch_state(1'b1);
        dispatch_random();
        dispatch_random();
        dispatch_instr(op_halt, zero_reg, zero_reg, zero_reg, '0);
        repeat (halt_len - 3) offer_instr(op_add, random_reg());
        wait_for_drain();
        repeat (10) @(posedge clock); // halted must hold
        #1;
        compare_arch_state(1'b1);
        $display("retired %0d instructions, %0d errors", retired, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== ooo_core.f ====
ooo_pkg.sv
arch_regfile.sv
alu_unit.sv
rename_stage.sv
res_station.sv
rob.sv
ooo_core.sv
ooo_core_tb.sv

// ==== Bender.yml ====
package:
  name: ooo_core

sources:
  - ooo_pkg.sv
  - arch_regfile.sv
  - alu_unit.sv
  - rename_stage.sv
  - res_station.sv
  - rob.sv
  - ooo_core.sv
  - target: test
    files:
      - ooo_core_tb.sv
